// ==== design/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

//**********************************************************************
// cache geometry
//**********************************************************************

// byte address width, shared by the processor port and the memory port
`define CACHE_ADDR_W 16

// one data word, also the width of a memory read
`define CACHE_WORD_W 16

// number of lines in the direct-mapped array, index is addr[6:4]
`define CACHE_SETS 8

// words per line, so a line covers 16 bytes and the byte offset steps by 2
`define CACHE_LINE_WORDS 8

//**********************************************************************
// buffering
//**********************************************************************

// default depth of both memory-side FIFOs
`define CACHE_FIFO_DEPTH 4

`endif

// ==== design/cache_pkg.sv ====
package cache_pkg;

`include "cache_cfg.svh"

// processor read, only the byte address of the word is carried
typedef struct packed {
	logic [`CACHE_ADDR_W-1:0] addr; // byte address, bit 0 ignored for 16-bit words
} cpu_req_t;

// processor response, returned one cycle after a hit
typedef struct packed {
	logic [`CACHE_WORD_W-1:0] data; // word read out of the data array
	logic [`CACHE_ADDR_W-1:0] addr; // address of the request that produced it
} cpu_rsp_t;

// one word read sent out to memory
typedef struct packed {
	logic [`CACHE_ADDR_W-1:0] addr; // line base plus the current read offset
} mem_req_t;

// one word coming back from memory, in request order
typedef struct packed {
	logic [`CACHE_WORD_W-1:0] data; // fill data for the data array
} mem_rsp_t;

// byte offset of a word inside a line, 0 to 14 in steps of 2
typedef logic [$clog2(`CACHE_LINE_WORDS * `CACHE_WORD_W / 8)-1:0] line_offset_t;

endpackage

// ==== design/cache_fill_fifo.sv ====
`timescale 1ns/100ps

`include "cache_cfg.svh"

// valid/ready FIFO used on both sides of the memory port
// a pushed entry shows up on the output one cycle later
module cache_fill_fifo #(
	parameter type T = logic [`CACHE_WORD_W-1:0], // payload carried through the buffer
	parameter int DEPTH = `CACHE_FIFO_DEPTH // number of entries
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid, // producer has an entry
	output logic in_ready, // low only when every slot is taken
	input T in_data,
	output logic out_valid, // head entry is valid
	input logic out_ready, // consumer takes the head
	output T out_data
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);
localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

T mem_q [DEPTH]; // circular storage, payload only
logic [PTR_W-1:0] wr_ptr_q; // next slot to write
logic [PTR_W-1:0] rd_ptr_q; // slot at the head
logic [CNT_W-1:0] count_q; // entries currently held
logic push;
logic pop;

// pointers wrap at DEPTH, which need not be a power of two
function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
	if (ptr == LAST_PTR) begin
		return '0;
	end
	return ptr + 1'b1;
endfunction

assign in_ready = (count_q != FULL_CNT); // a push and pop together are fine when not full
assign out_valid = (count_q != '0);
assign out_data = mem_q[rd_ptr_q]; // head is read straight out of storage

assign push = in_valid & in_ready;
assign pop = out_valid & out_ready;

//**********************************************************************
// storage and pointers
//**********************************************************************

always_ff @(posedge clk) begin
	if (push) begin
		mem_q[wr_ptr_q] <= in_data;
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		wr_ptr_q <= '0;
		rd_ptr_q <= '0;
		count_q <= '0;
	end else begin
		if (push) begin
			wr_ptr_q <= ptr_inc(wr_ptr_q);
		end
		if (pop) begin
			rd_ptr_q <= ptr_inc(rd_ptr_q);
		end
		case ({push, pop})
			2'b10: count_q <= count_q + 1'b1; // only a push, one more entry
			2'b01: count_q <= count_q - 1'b1; // only a pop, one fewer
			default: count_q <= count_q; // neither, or both in the same cycle
		endcase
	end
end

// a push never lands on a slot that still holds an entry
a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
	push && out_valid |-> (wr_ptr_q != rd_ptr_q));

// a pop never takes a slot that was not written, equal pointers only mean full here
a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
	pop && (rd_ptr_q == wr_ptr_q) |-> (count_q == FULL_CNT));

// a waiting head entry is not disturbed by pushes behind it
a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
	out_valid && !out_ready |=> out_valid && (out_data == $past(out_data)));

endmodule

// ==== design/cache_arrays.sv ====
`timescale 1ns/100ps

`include "cache_cfg.svh"

// tag, valid and data storage of the direct-mapped cache
// lookups come from the processor port, fills come from the miss FSM
module cache_arrays
	import cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic cpu_req_valid, // processor has a read
	input logic cpu_req_ready, // low while a fill is running
	input cpu_req_t cpu_req,
	output logic cpu_rsp_valid, // high the cycle after a hit is taken
	output cpu_rsp_t cpu_rsp,
	output logic miss_detected, // request taken and it did not hit
	output cpu_req_t miss_addr, // address that missed, for the FSM to latch
	input cpu_req_t base_addr, // line being filled
	input logic write_data_array, // write one fill word
	input line_offset_t write_offset, // byte offset of that word in the line
	input mem_rsp_t write_data, // word straight from the response FIFO
	input logic write_tag_array // line complete, set tag and valid
);

localparam int OFF_W = $bits(line_offset_t); // byte offset bits, 4
localparam int IDX_W = $clog2(`CACHE_SETS); // index bits, 3
localparam int WSEL_W = $clog2(`CACHE_LINE_WORDS); // word select bits, 3
localparam int TAG_LO = OFF_W + IDX_W; // tag starts at bit 7
localparam int TAG_W = `CACHE_ADDR_W - TAG_LO; // 9 tag bits

logic [TAG_W-1:0] tag_mem [`CACHE_SETS]; // one tag per set
logic [`CACHE_SETS-1:0] valid_q; // only the valid bits are cleared by reset
logic [`CACHE_WORD_W-1:0] data_mem [`CACHE_SETS * `CACHE_LINE_WORDS]; // addressed by {set, word}

logic req_take;
logic hit;
logic [IDX_W-1:0] req_idx;
logic [TAG_W-1:0] req_tag;
logic [WSEL_W-1:0] req_wsel;
logic [IDX_W-1:0] fill_idx;
logic [TAG_W-1:0] fill_tag;
logic [WSEL_W-1:0] fill_wsel;

//**********************************************************************
// lookup
//**********************************************************************

assign req_idx = cpu_req.addr[TAG_LO-1:OFF_W];
assign req_tag = cpu_req.addr[`CACHE_ADDR_W-1:TAG_LO];
assign req_wsel = cpu_req.addr[OFF_W-1:1]; // bit 0 is the byte within the word

assign req_take = cpu_req_valid & cpu_req_ready; // handshake on the processor port
assign hit = req_take & valid_q[req_idx] & (tag_mem[req_idx] == req_tag);

assign miss_detected = req_take & ~hit; // FSM only acts on this while idle
assign miss_addr = cpu_req;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		cpu_rsp_valid <= 1'b0;
	end else begin
		cpu_rsp_valid <= hit; // one cycle lookup latency
	end
end

// response payload only changes on a hit
always_ff @(posedge clk) begin
	if (hit) begin
		cpu_rsp.data <= data_mem[{req_idx, req_wsel}];
		cpu_rsp.addr <= cpu_req.addr;
	end
end

//**********************************************************************
// fill writes
//**********************************************************************

assign fill_idx = base_addr.addr[TAG_LO-1:OFF_W];
assign fill_tag = base_addr.addr[`CACHE_ADDR_W-1:TAG_LO];
assign fill_wsel = write_offset[OFF_W-1:1]; // offset steps by 2, so drop bit 0

always_ff @(posedge clk) begin
	if (write_data_array) begin
		data_mem[{fill_idx, fill_wsel}] <= write_data.data;
	end
	if (write_tag_array) begin
		tag_mem[fill_idx] <= fill_tag;
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		valid_q <= '0;
	end else if (write_tag_array) begin
		valid_q[fill_idx] <= 1'b1; // line becomes visible only after all eight words
	end
end

// the FSM finishes the data words before it commits the tag
a_tag_data_apart: assert property (@(posedge clk) disable iff (!rst_n)
	!(write_tag_array && write_data_array));

endmodule

// ==== design/cache_fill_fsm.sv ====
`timescale 1ns/100ps

`include "cache_cfg.svh"

// miss handler, reads a whole line from memory and writes it into the arrays
// the read side and the write side run independently, linked only by the FIFOs
module cache_fill_fsm
	import cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic miss_detected, // lookup missed on a taken request
	input cpu_req_t miss_addr, // address that missed
	output logic busy, // fill in progress, stalls the processor port
	output logic req_valid, // memory read pending
	input logic req_ready, // request FIFO has room
	output mem_req_t req_addr, // word address of the pending read
	input logic rsp_valid, // response FIFO has a word
	output logic rsp_ready, // take it while the line is not complete
	output logic write_data_array, // data array write enable
	output line_offset_t write_offset, // byte offset of the word being written
	output logic write_tag_array, // tag and valid write enable, one cycle
	output cpu_req_t base_addr // line base address of the current fill
);

localparam int OFF_W = $bits(line_offset_t);
localparam line_offset_t OFF_STEP = line_offset_t'(`CACHE_WORD_W / 8); // 2 bytes per word
localparam line_offset_t OFF_LAST = line_offset_t'((`CACHE_LINE_WORDS - 1) * (`CACHE_WORD_W / 8));

logic fill_start; // idle and a miss arrives
logic push; // read accepted by the request FIFO
logic pop; // word taken from the response FIFO
line_offset_t rd_off_q; // offset of the next read
line_offset_t wr_off_q; // offset of the next array write
logic read_done_q; // all eight reads issued
logic write_done_q; // all eight words written

assign fill_start = ~busy & miss_detected;
assign push = req_valid & req_ready;
assign pop = rsp_valid & rsp_ready;

//**********************************************************************
// state and captured line address
//**********************************************************************

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		busy <= 1'b0;
	end else if (write_tag_array) begin
		busy <= 1'b0; // tag written this cycle, back to idle on this edge
	end else if (fill_start) begin
		busy <= 1'b1; // raised the cycle after the miss was taken
	end
end

// offset bits are cleared so the read address is the line base plus offset
always_ff @(posedge clk) begin
	if (fill_start) begin
		base_addr.addr <= {miss_addr.addr[`CACHE_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
	end
end

//**********************************************************************
// read side
//**********************************************************************

assign req_valid = busy & ~read_done_q;
assign req_addr.addr = base_addr.addr + {{(`CACHE_ADDR_W - OFF_W){1'b0}}, rd_off_q};

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		rd_off_q <= '0;
		read_done_q <= 1'b0;
	end else if (write_tag_array) begin
		rd_off_q <= '0; // ready for the next miss
		read_done_q <= 1'b0;
	end else if (push) begin
		rd_off_q <= rd_off_q + OFF_STEP; // only moves on an accepted read, stalls just pause it
		if (rd_off_q == OFF_LAST) begin
			read_done_q <= 1'b1; // the offset 14 read went out
		end
	end
end

//**********************************************************************
// write side
//**********************************************************************

assign rsp_ready = busy & ~write_done_q;
assign write_data_array = pop; // every popped word goes straight into the array
assign write_offset = wr_off_q;
assign write_tag_array = busy & write_done_q; // the cycle after the eighth word

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		wr_off_q <= '0;
		write_done_q <= 1'b0;
	end else if (write_tag_array) begin
		wr_off_q <= '0;
		write_done_q <= 1'b0;
	end else if (pop) begin
		wr_off_q <= wr_off_q + OFF_STEP; // response gaps simply hold the counter
		if (wr_off_q == OFF_LAST) begin
			write_done_q <= 1'b1;
		end
	end
end

// a word is only popped for a read that already went out, so writes never overtake reads
a_no_write_ahead: assert property (@(posedge clk) disable iff (!rst_n)
	pop |-> read_done_q || (wr_off_q < rd_off_q));

// memory only answers reads of the current fill, so nothing waits to be popped while idle
a_no_pop_idle: assert property (@(posedge clk) disable iff (!rst_n)
	!busy |-> !rsp_valid);

// a read held back by the request FIFO keeps its address
a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
	req_valid && !req_ready |=> req_valid && (req_addr == $past(req_addr)));

endmodule

// ==== design/cache_fill_top.sv ====
`timescale 1ns/100ps

`include "cache_cfg.svh"

// line-fill subsystem of the data cache
// arrays do the lookup, the FSM fetches missing lines through two FIFOs
module cache_fill_top
	import cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic cpu_req_valid, // processor read request
	output logic cpu_req_ready, // low while a line is being filled
	input cpu_req_t cpu_req,
	output logic cpu_rsp_valid, // hit data, no backpressure
	output cpu_rsp_t cpu_rsp,
	output logic mem_req_valid, // word read to memory
	input logic mem_req_ready,
	output mem_req_t mem_req,
	input logic mem_rsp_valid, // word returned by memory, in request order
	output logic mem_rsp_ready,
	input mem_rsp_t mem_rsp
);

logic busy; // fill in progress
logic miss_detected;
cpu_req_t miss_addr;
cpu_req_t base_addr; // line under fill, indexes the array writes
logic fsm_req_valid; // FSM to request FIFO
logic fsm_req_ready;
mem_req_t fsm_req_addr;
logic fill_rsp_valid; // response FIFO to FSM
logic fill_rsp_ready;
mem_rsp_t fill_word; // head of the response FIFO, written into the data array
logic write_data_array;
logic write_tag_array;
line_offset_t write_offset;

assign cpu_req_ready = ~busy; // the processor port stalls for the whole fill

//**********************************************************************
// lookup and storage
//**********************************************************************

cache_arrays u_arrays (
	.clk (clk),
	.rst_n (rst_n),
	.cpu_req_valid (cpu_req_valid),
	.cpu_req_ready (cpu_req_ready),
	.cpu_req (cpu_req),
	.cpu_rsp_valid (cpu_rsp_valid),
	.cpu_rsp (cpu_rsp),
	.miss_detected (miss_detected),
	.miss_addr (miss_addr),
	.base_addr (base_addr),
	.write_data_array (write_data_array),
	.write_offset (write_offset),
	.write_data (fill_word),
	.write_tag_array (write_tag_array)
);

//**********************************************************************
// miss handling
//**********************************************************************

cache_fill_fsm u_fsm (
	.clk (clk),
	.rst_n (rst_n),
	.miss_detected (miss_detected),
	.miss_addr (miss_addr),
	.busy (busy),
	.req_valid (fsm_req_valid),
	.req_ready (fsm_req_ready),
	.req_addr (fsm_req_addr),
	.rsp_valid (fill_rsp_valid),
	.rsp_ready (fill_rsp_ready),
	.write_data_array (write_data_array),
	.write_offset (write_offset),
	.write_tag_array (write_tag_array),
	.base_addr (base_addr)
);

// outgoing reads, the FIFO head is the external memory request
cache_fill_fifo #(.T(mem_req_t), .DEPTH(`CACHE_FIFO_DEPTH)) u_req_fifo (
	.clk (clk),
	.rst_n (rst_n),
	.in_valid (fsm_req_valid),
	.in_ready (fsm_req_ready),
	.in_data (fsm_req_addr),
	.out_valid (mem_req_valid),
	.out_ready (mem_req_ready),
	.out_data (mem_req)
);

// returning words, drained by the FSM one per array write
cache_fill_fifo #(.T(mem_rsp_t), .DEPTH(`CACHE_FIFO_DEPTH)) u_rsp_fifo (
	.clk (clk),
	.rst_n (rst_n),
	.in_valid (mem_rsp_valid),
	.in_ready (mem_rsp_ready),
	.in_data (mem_rsp),
	.out_valid (fill_rsp_valid),
	.out_ready (fill_rsp_ready),
	.out_data (fill_word)
);

endmodule

// ==== verification/tb_cache_fill.sv ====
`timescale 1ns/100ps

`include "cache_cfg.svh"

// testbench for the cache line-fill subsystem
// random processor reads are checked against a reference cache, memory answers in order
module tb_cache_fill
	import cache_pkg::*;
();

localparam int N_REQ = 300; // processor requests, the retry after a miss comes on top
localparam int TIMEOUT_CYC = N_REQ * 40; // room for a slow fill on every request
localparam logic [15:0] MEM_XOR = 16'hc3a5; // memory word at byte address a is a ^ MEM_XOR

logic clk = 1'b0;
logic rst_n;
logic cpu_req_valid;
logic cpu_req_ready;
cpu_req_t cpu_req;
logic cpu_rsp_valid;
cpu_rsp_t cpu_rsp;
logic mem_req_valid;
logic mem_req_ready;
mem_req_t mem_req;
logic mem_rsp_valid;
logic mem_rsp_ready;
mem_rsp_t mem_rsp;

int cyc = 0; // rising edges since time zero
int cpu_errors = 0; // found on the processor side
int mem_errors = 0; // found by the memory model
int hit_count = 0;
int miss_count = 0;
int reads_seen; // memory reads of the current fill
int fill_id; // bumped on every predicted miss
logic fill_active; // a miss is outstanding
logic [15:0] fill_base; // line base of the outstanding miss
logic [31:0] cpu_rnd;
logic [31:0] mem_rnd;
logic [8:0] model_tag [`CACHE_SETS]; // reference cache, tag is addr[15:7]
logic [`CACHE_SETS-1:0] model_valid;
logic rsp_expected; // a hit was taken on the last edge
cpu_rsp_t exp_rsp;
logic [15:0] pend_addr_q [$]; // reads accepted by memory and not yet answered
int pend_due_q [$]; // cycle from which each answer may be presented

cache_fill_top UUT (
	.clk (clk),
	.rst_n (rst_n),
	.cpu_req_valid (cpu_req_valid),
	.cpu_req_ready (cpu_req_ready),
	.cpu_req (cpu_req),
	.cpu_rsp_valid (cpu_rsp_valid),
	.cpu_rsp (cpu_rsp),
	.mem_req_valid (mem_req_valid),
	.mem_req_ready (mem_req_ready),
	.mem_req (mem_req),
	.mem_rsp_valid (mem_rsp_valid),
	.mem_rsp_ready (mem_rsp_ready),
	.mem_rsp (mem_rsp)
);

always #20 clk = ~clk; // 40 ns period

//**********************************************************************
// helpers
//**********************************************************************

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// three tags over all eight sets, so lines get both reused and evicted
function automatic cpu_req_t pick_addr(input logic [31:0] r);
	cpu_req_t req;
	logic [8:0] tag;
	case (r[9:8])
		2'd1: tag = 9'h0a5;
		2'd2: tag = 9'h1c2;
		default: tag = 9'h003; // this one comes up twice as often
	endcase
	req.addr = {tag, r[14:12], r[18:16], 1'b0}; // tag, index, word, byte 0
	return req;
endfunction

task automatic compare_rsp(input cpu_rsp_t exp, input cpu_rsp_t act);
	if (act !== exp) begin
		cpu_errors++;
		$display("FAILED at %0t: cpu_rsp expected %h actual %h", $time, exp, act);
	end
endtask

task automatic compare_mem_req(input mem_req_t exp, input mem_req_t act);
	if (act !== exp) begin
		mem_errors++;
		$display("FAILED at %0t: mem_req expected %h actual %h", $time, exp, act);
	end
endtask

task automatic close_run(input logic timed_out);
	$display("hits %0d misses %0d cycles %0d, processor errors %0d, memory errors %0d",
		hit_count, miss_count, cyc, cpu_errors, mem_errors);
	if (timed_out || cpu_errors != 0 || mem_errors != 0) begin
		$display("TB FAILED");
	end else begin
		$display("TB PASSED");
	end
	$finish;
endtask

// outputs are read at the falling edge, where the next rising edge will see them
task automatic sample_point();
	@(negedge clk);
	if (rsp_expected) begin
		if (!cpu_rsp_valid) begin
			cpu_errors++;
			$display("at %0t: hit on address %h gave no response", $time, exp_rsp.addr);
		end else begin
			compare_rsp(exp_rsp, cpu_rsp);
		end
	end else if (cpu_rsp_valid) begin
		cpu_errors++;
		$display("at %0t: response for %h without a request that hit", $time, cpu_rsp.addr);
	end
	rsp_expected = 1'b0;
endtask

task automatic drive_point();
	@(posedge clk);
	#2; // inputs change a little after the edge
endtask

//**********************************************************************
// processor side
//**********************************************************************

// present one read, return whether the reference cache saw a miss
task automatic send_req(input cpu_req_t req, output logic missed);
	logic taken;
	logic [2:0] idx;
	logic [8:0] tag;
	taken = 1'b0;
	missed = 1'b0;
	idx = req.addr[6:4];
	tag = req.addr[15:7];
	cpu_req_valid = 1'b1;
	cpu_req = req;
	while (!taken) begin
		sample_point();
		if (cpu_req_ready) begin
			taken = 1'b1;
			if (model_valid[idx] && model_tag[idx] == tag) begin
				hit_count++;
				rsp_expected = 1'b1; // checked at the next sample point
				exp_rsp.data = req.addr ^ MEM_XOR;
				exp_rsp.addr = req.addr;
			end else begin
				miss_count++;
				missed = 1'b1;
				fill_base = {req.addr[15:4], 4'h0};
				fill_id++;
				fill_active = 1'b1;
				model_valid[idx] = 1'b1; // the line holds this tag once the fill is over
				model_tag[idx] = tag;
			end
		end
		drive_point();
	end
	cpu_req_valid = 1'b0;
endtask

// the port stalls right after the miss and reopens once all eight words are in
task automatic wait_fill();
	sample_point();
	if (cpu_req_ready) begin
		cpu_errors++;
		$display("at %0t: miss on line %h did not stall the processor port", $time, fill_base);
	end
	while (!cpu_req_ready) begin
		drive_point();
		sample_point();
	end
	fill_active = 1'b0;
	if (reads_seen != 8) begin
		cpu_errors++;
		$display("at %0t: fill of line %h ended after %0d memory reads instead of eight",
			$time, fill_base, reads_seen);
	end
	if (pend_addr_q.size() != 0 || mem_rsp_valid) begin
		cpu_errors++;
		$display("at %0t: fill of line %h ended before memory answered every read",
			$time, fill_base);
	end
	drive_point();
endtask

initial begin
	cpu_req_t req;
	logic missed;
	int gap;
	cpu_req_valid = 1'b0;
	cpu_req = '0;
	rst_n = 1'b0;
	model_valid = '0;
	rsp_expected = 1'b0;
	exp_rsp = '0;
	fill_active = 1'b0;
	fill_id = 0;
	fill_base = '0;
	cpu_rnd = 32'h460f;
	repeat (2) @(posedge clk);
	#2;
	rst_n = 1'b1;
	@(negedge clk);
	if (!cpu_req_ready || mem_req_valid || cpu_rsp_valid) begin
		cpu_errors++;
		$display("at %0t: DUT outputs not in their reset state after reset", $time);
	end
	drive_point();
	for (int i = 0; i < N_REQ; i++) begin
		cpu_rnd = xorshift32(cpu_rnd);
		gap = int'(cpu_rnd[1:0]); // 0 to 3 idle cycles before the request
		repeat (gap) begin
			sample_point();
			drive_point();
		end
		req = pick_addr(cpu_rnd);
		send_req(req, missed);
		if (missed) begin
			wait_fill();
			send_req(req, missed); // the same read again, now a hit in the model
		end
	end
	sample_point(); // response of the last request
	close_run(1'b0);
end

//**********************************************************************
// memory model
//**********************************************************************

initial begin
	mem_req_t exp_req;
	logic rsp_taken;
	int seen_fill_id;
	mem_req_ready = 1'b0;
	mem_rsp_valid = 1'b0;
	mem_rsp = '0;
	mem_rnd = ~32'h460f; // own stream, so stalls do not shift the request sequence
	reads_seen = 0;
	seen_fill_id = 0;
	forever begin
		@(negedge clk);
		rsp_taken = 1'b0;
		if (seen_fill_id != fill_id) begin
			seen_fill_id = fill_id; // a new miss, count its reads from zero
			reads_seen = 0;
		end
		if (rst_n && mem_req_valid && mem_req_ready) begin
			if (!fill_active) begin
				mem_errors++;
				$display("at %0t: memory read of %h with no miss outstanding", $time, mem_req.addr);
			end else if (reads_seen >= 8) begin
				mem_errors++;
				$display("at %0t: extra memory read of %h for line %h", $time, mem_req.addr,
					fill_base);
			end else begin
				exp_req.addr = fill_base + 16'(2 * reads_seen); // ascending word order
				compare_mem_req(exp_req, mem_req);
			end
			reads_seen++;
			mem_rnd = xorshift32(mem_rnd);
			pend_addr_q.push_back(mem_req.addr);
			pend_due_q.push_back(cyc + 1 + int'(mem_rnd[5:4])); // 0 to 3 cycles late
		end
		if (rst_n && mem_rsp_valid && mem_rsp_ready) begin
			rsp_taken = 1'b1;
		end
		drive_point();
		if (rsp_taken) begin
			mem_rsp_valid = 1'b0;
		end
		if (!mem_rsp_valid && pend_addr_q.size() != 0 && pend_due_q[0] <= cyc) begin
			mem_rsp_valid = 1'b1; // held until the response FIFO takes it
			mem_rsp.data = pend_addr_q.pop_front() ^ MEM_XOR;
			void'(pend_due_q.pop_front());
		end
		mem_rnd = xorshift32(mem_rnd);
		mem_req_ready = (mem_rnd[1:0] != 2'b00); // stalls about one cycle in four
	end
end

// stops a run that hangs on a fill that never ends
always @(posedge clk) begin
	cyc <= cyc + 1;
	if (cyc >= TIMEOUT_CYC) begin
		$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYC);
		close_run(1'b1);
	end
end

endmodule

// ==== cache_fill.f ====
+incdir+design
design/cache_pkg.sv
design/cache_fill_fifo.sv
design/cache_arrays.sv
design/cache_fill_fsm.sv
design/cache_fill_top.sv
verification/tb_cache_fill.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the cache fill testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_cache_fill \
	-f cache_fill.f -o sim_cache_fill > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim_cache_fill > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -qx "TB PASSED" sim.log; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed, see sim.log"
exit 1
